//--- Bender.yml
package:
  name: memsystem

sources:
  - hw/memSysPkg.sv
  - hw/cacheArray.sv
  - hw/bankedMemory.sv
  - hw/cacheController.sv
  - hw/memSystem.sv
  - target: simulation
    files:
      - bench/memSystemTb.sv

//--- bench/memSystemTb.sv
// ----------------------------------------
// Memory system testbench
// Directed tests against a golden memory
// and a shadow of the cached lines
// ----------------------------------------
`default_nettype none

module memSystemTb;
    timeunit 1ns;
    timeprecision 100ps;

    import memSysPkg::*;

    localparam int timeoutCycles = 200;

    logic                 clk;
    logic                 rst;
    logic [addrWidth-1:0] Addr;
    logic [dataWidth-1:0] DataIn;
    logic                 Rd;
    logic                 Wr;
    logic [dataWidth-1:0] DataOut;
    logic                 Done;
    logic                 Stall;
    logic                 CacheHit;
    logic                 err;

    int     errors;
    integer seed;

    logic [dataWidth-1:0]  golden [2 ** (addrWidth - 1)];  // One entry per word
    logic [tagWidth-1:0]   shadowTag [2 ** indexWidth];
    logic                  shadowValid [2 ** indexWidth];

    memSystem #(.bankLatency(4)) UUT (
        .clk(clk), .rst(rst), .Addr(Addr), .DataIn(DataIn), .Rd(Rd), .Wr(Wr),
        .DataOut(DataOut), .Done(Done), .Stall(Stall), .CacheHit(CacheHit), .err(err)
    );

    always #4 clk = ~clk;

    task automatic checkData(input string name, input logic [dataWidth-1:0] expVal,
                             input logic [dataWidth-1:0] actVal);
        if (actVal !== expVal) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
            errors++;
        end
    endtask

    task automatic checkBit(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("Error at %0t ns: %s expected %b, got %b", $time, name, expVal, actVal);
            errors++;
        end
    endtask

    task automatic checkCycles(input string name, input int expVal, input int actVal);
        if (actVal != expVal) begin
            $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, expVal, actVal);
            errors++;
        end
    endtask

    // Random tag and word around a chosen line index
    task automatic pickAddr(input logic [indexWidth-1:0] idx, output logic [addrWidth-1:0] addr);
        logic [31:0] r;
        r = $random(seed);
        addr = {r[tagWidth-1:0], idx, r[6:5], 1'b0};
    endtask

    // Called 1 ns after a rising edge; returns 1 ns after a later rising edge
    task automatic access(input logic [addrWidth-1:0] addr, input logic [dataWidth-1:0] data,
                          input logic rd, input logic wr, output logic [dataWidth-1:0] rdData,
                          output logic hitOut, output logic errOut, output int latency);
        int         n;
        bit         seen;
        ctrlState_t stateNow;
        n = 0;
        seen = 0;
        rdData = '0;
        hitOut = 1'b0;
        errOut = 1'b0;
        Addr = addr;
        DataIn = data;
        Rd = rd;
        Wr = wr;
        while (!seen && (n < timeoutCycles)) begin
            @(negedge clk);
            if (Done) begin
                seen = 1;
                rdData = DataOut;
                hitOut = CacheHit;
                errOut = err;
            end else begin
                if (n > 0) checkBit("Stall", 1'b1, Stall);  // Idle only in the first cycle
                n++;
            end
        end
        latency = n;
        if (!seen) begin
            stateNow = UUT.ctrl.state;
            $display("Timeout at %0t ns: Done never came for address %h, controller in %s",
                     $time, addr, stateNow.name());
            errors++;
        end
        @(posedge clk);
        #1;
        Rd = 1'b0;
        Wr = 1'b0;
        @(negedge clk);
        checkBit("Done", 1'b0, Done);  // Pulses are one cycle wide
        checkBit("err", 1'b0, err);
        @(posedge clk);
        #1;
    endtask

    task automatic readCheck(input logic [addrWidth-1:0] addr);
        logic [indexWidth-1:0] idx;
        logic [tagWidth-1:0]   tag;
        logic                  expHit;
        logic [dataWidth-1:0]  got;
        logic                  hitOut;
        logic                  errOut;
        int                    lat;
        idx = addr[offsetWidth +: indexWidth];
        tag = addr[addrWidth-1 -: tagWidth];
        expHit = shadowValid[idx] && (shadowTag[idx] == tag);
        access(addr, '0, 1'b1, 1'b0, got, hitOut, errOut, lat);
        checkData("DataOut", golden[addr[addrWidth-1:1]], got);
        checkBit("CacheHit", expHit, hitOut);
        checkBit("err", 1'b0, errOut);
        if (expHit) checkCycles("Read hit latency", 2, lat);
        shadowValid[idx] = 1'b1;  // Line is present after any read
        shadowTag[idx] = tag;
    endtask

    task automatic writeCheck(input logic [addrWidth-1:0] addr, input logic [dataWidth-1:0] data);
        logic [dataWidth-1:0] got;
        logic                 hitOut;
        logic                 errOut;
        int                   lat;
        access(addr, data, 1'b0, 1'b1, got, hitOut, errOut, lat);
        checkBit("CacheHit", 1'b0, hitOut);
        checkBit("err", 1'b0, errOut);
        golden[addr[addrWidth-1:1]] = data;  // No allocate, shadow unchanged
    endtask

    task automatic resetTest();
        repeat (4) begin
            @(negedge clk);
            checkBit("Done", 1'b0, Done);
            checkBit("Stall", 1'b0, Stall);
            checkBit("CacheHit", 1'b0, CacheHit);
            checkBit("err", 1'b0, err);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic missThenHitTest();
        logic [addrWidth-1:0] a;
        pickAddr(8'h11, a);
        readCheck(a);
        readCheck(a);
    endtask

    task automatic writeThroughTest();
        logic [addrWidth-1:0] a;
        pickAddr(8'h22, a);
        writeCheck(a, 16'($random(seed)));
        readCheck(a);
    endtask

    task automatic writeHitTest();
        logic [addrWidth-1:0] a;
        pickAddr(8'h33, a);
        for (int w = 0; w < bankCount; w++) begin
            writeCheck({a[addrWidth-1:offsetWidth], 2'(w), 1'b0}, 16'($random(seed)));
        end
        readCheck(a);  // Brings the line in
        writeCheck(a, 16'($random(seed)));
        for (int w = 0; w < bankCount; w++) begin
            readCheck({a[addrWidth-1:offsetWidth], 2'(w), 1'b0});
        end
    endtask

    task automatic conflictTest();
        logic [addrWidth-1:0] a;
        logic [addrWidth-1:0] b;
        pickAddr(8'h44, a);
        b = {a[addrWidth-1 -: tagWidth] ^ (5'($random(seed)) | 5'h1), a[10:0]};
        writeCheck(a, 16'($random(seed)));
        writeCheck(b, 16'($random(seed)));
        readCheck(a);
        readCheck(b);
        readCheck(a);
    endtask

    task automatic illegalTest();
        logic [addrWidth-1:0] a;
        logic [dataWidth-1:0] got;
        logic                 hitOut;
        logic                 errOut;
        int                   lat;
        pickAddr(8'h55, a);
        writeCheck(a, 16'($random(seed)));
        access(a, ~golden[a[addrWidth-1:1]], 1'b1, 1'b1, got, hitOut, errOut, lat);
        checkBit("err", 1'b1, errOut);
        checkCycles("Illegal request latency", 2, lat);
        readCheck(a);  // Must still hold the earlier write
    endtask

    initial begin
        errors = 0;
        seed = 32'hd59d_bc9a;
        clk = 1'b0;
        rst = 1'b1;
        Addr = '0;
        DataIn = '0;
        Rd = 1'b0;
        Wr = 1'b0;
        for (int i = 0; i < 2 ** (addrWidth - 1); i++) golden[i] = '0;
        for (int i = 0; i < 2 ** indexWidth; i++) shadowValid[i] = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        resetTest();
        missThenHitTest();
        writeThroughTest();
        writeHitTest();
        conflictTest();
        illegalTest();
        $display("Tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/bankedMemory.sv
// ----------------------------------------
// Banked memory model
// Four word-interleaved banks selected by
// address bits 2..1; each bank stays busy
// for bankLatency cycles after a strobe
// ----------------------------------------
`default_nettype none

module bankedMemory #(
    parameter int bankLatency = 4
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            rdStrobe,
    input  logic                            wrStrobe,
    input  logic [memSysPkg::addrWidth-1:0]  memAddr,
    input  logic [memSysPkg::dataWidth-1:0]  wrData,
    output logic [memSysPkg::dataWidth-1:0]  readData,
    output logic [memSysPkg::bankCount-1:0]  busy
);

    import memSysPkg::*;

    localparam int bankBits = $clog2(bankCount);
    localparam int rowBits  = addrWidth - bankBits - 1;
    localparam int rowCount = 2 ** rowBits;
    localparam int cntWidth = $clog2(bankLatency + 1);

    // Contents start at zero
    logic [dataWidth-1:0] bankMem [bankCount][rowCount] = '{default: '0};

    logic [cntWidth-1:0] busyCnt [bankCount];
    logic [bankCount-1:0] rdPend;            // Read outstanding in the bank
    logic [rowBits-1:0]  pendRow [bankCount];
    logic [bankBits-1:0] bankSel;
    logic [rowBits-1:0]  rowSel;
    logic                strobe;

    assign bankSel = memAddr[bankBits:1];   // Bit 0 is the byte lane, ignored
    assign rowSel  = memAddr[addrWidth-1 -: rowBits];
    assign strobe  = rdStrobe || wrStrobe;

    always_comb begin
        for (int b = 0; b < bankCount; b++) begin
            busy[b] = (busyCnt[b] != '0);
        end
    end

    // Per-bank busy counters
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int b = 0; b < bankCount; b++) begin
                busyCnt[b] <= '0;
            end
            rdPend <= '0;
        end else begin
            for (int b = 0; b < bankCount; b++) begin
                if (strobe && (bankSel == bankBits'(b))) begin
                    busyCnt[b] <= cntWidth'(bankLatency);
                    rdPend[b]  <= rdStrobe;
                end else if (busyCnt[b] != '0) begin
                    busyCnt[b] <= busyCnt[b] - 1'b1;
                    if (busyCnt[b] == cntWidth'(1)) begin
                        rdPend[b] <= 1'b0;  // Data handed out this edge
                    end
                end
            end
        end
    end

    // Array access; writes land at the strobe
    always_ff @(posedge clk) begin
        if (wrStrobe) begin
            bankMem[bankSel][rowSel] <= wrData;
        end
        if (rdStrobe) begin
            pendRow[bankSel] <= rowSel;
        end
        // Read data shows up the cycle busy drops and holds until the next read
        for (int b = 0; b < bankCount; b++) begin
            if (rdPend[b] && (busyCnt[b] == cntWidth'(1))) begin
                readData <= bankMem[b][pendRow[b]];
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) strobe |-> !busy[bankSel])
        else $error("bankedMemory: strobe to busy bank %0d", bankSel);

    assert property (@(posedge clk) disable iff (rst) !(rdStrobe && wrStrobe))
        else $error("bankedMemory: read and write strobe together");

endmodule

`default_nettype wire

//--- hw/cacheArray.sv
// ----------------------------------------
// Cache array
// Direct-mapped tag, valid and data store
// with combinational compare, write-hit
// update and word-by-word line fill
// ----------------------------------------
`default_nettype none

module cacheArray (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            compare,
    input  logic                            writeWord,
    input  logic                            fill,
    input  logic [memSysPkg::tagWidth-1:0]   tagIn,
    input  logic [memSysPkg::indexWidth-1:0] index,
    input  logic [1:0]                      wordSel,
    input  logic [memSysPkg::dataWidth-1:0]  wrData,
    output logic                            hit,
    output logic [memSysPkg::dataWidth-1:0]  dataOut
);

    import memSysPkg::*;

    localparam int lineCount = 2 ** indexWidth;

    logic [dataWidth-1:0] dataMem [lineCount][bankCount];
    logic [tagWidth-1:0]  tagMem  [lineCount];
    logic [lineCount-1:0] validBits;
    logic                 lastWord;
    logic                 wordWrite;

    assign lastWord = (wordSel == 2'(bankCount - 1));

    // Lookup
    assign hit     = compare && validBits[index] && (tagMem[index] == tagIn);
    assign dataOut = dataMem[index][wordSel];

    // Store on a fill, or on a write that found the line
    assign wordWrite = fill || (writeWord && hit);

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
        end else if (fill && lastWord) begin
            validBits[index] <= 1'b1;  // Line complete
        end
    end

    always_ff @(posedge clk) begin
        if (wordWrite) begin
            dataMem[index][wordSel] <= wrData;
        end
        // Tag goes in together with the last word of the line
        if (fill && lastWord) begin
            tagMem[index] <= tagIn;
        end
    end

    // The controller never writes through and fills in the same cycle
    assert property (@(posedge clk) disable iff (rst) !(fill && writeWord))
        else $error("cacheArray: fill and writeWord high together");

endmodule

`default_nettype wire

//--- hw/cacheController.sv
// ----------------------------------------
// Cache controller
// Sequences tag compare, four-word line
// fill, allocate and write-through, and
// drives the requester status outputs
// ----------------------------------------
`default_nettype none

module cacheController (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [memSysPkg::addrWidth-1:0]  Addr,
    input  logic                            Rd,
    input  logic                            Wr,
    input  logic                            hit,
    input  logic [memSysPkg::bankCount-1:0]  busy,
    output logic                            Done,
    output logic                            Stall,
    output logic                            CacheHit,
    output logic                            err,
    output logic                            compare,
    output logic                            writeWord,
    output logic                            fill,
    output logic [1:0]                      wordSel,
    output logic                            rdStrobe,
    output logic                            wrStrobe,
    output logic [memSysPkg::addrWidth-1:0]  memAddr
);

    import memSysPkg::*;

    ctrlState_t state;
    ctrlState_t nextState;

    logic [1:0] fillCnt;    // Word being fetched during a line fill
    logic       wasMiss;    // Request already went through a fill
    logic       hitSeen;
    logic       illegal;
    logic       inFill;
    logic       bankBusy;

    assign illegal = Rd && Wr;
    assign inFill  = (state == stFillIssue) || (state == stFillWait);

    // Word and bank follow the fill counter while filling, the request otherwise
    assign wordSel  = inFill ? fillCnt : Addr[2:1];
    assign bankBusy = busy[wordSel];

    assign memAddr = inFill ? {Addr[addrWidth-1:offsetWidth], fillCnt, 1'b0}
                            : {Addr[addrWidth-1:1], 1'b0};

    // Status outputs
    assign Done     = (state == stDone);
    assign Stall    = (state != stIdle) && (state != stDone);
    assign CacheHit = Done && hitSeen;
    assign err      = Done && illegal;

    always_comb begin
        nextState = state;
        compare   = 1'b0;
        writeWord = 1'b0;
        fill      = 1'b0;
        rdStrobe  = 1'b0;
        wrStrobe  = 1'b0;
        unique case (state)
            stIdle: begin
                if (Rd || Wr) begin
                    nextState = stCompare;
                end
            end
            stCompare: begin
                compare = 1'b1;
                if (illegal) begin
                    nextState = stDone;      // Finish without touching anything
                end else if (Wr) begin
                    writeWord = 1'b1;        // Only lands if the line is present
                    nextState = stWriteMem;
                end else if (hit) begin
                    nextState = stDone;
                end else begin
                    nextState = stFillIssue;
                end
            end
            stFillIssue: begin
                if (!bankBusy) begin
                    rdStrobe  = 1'b1;
                    nextState = stFillWait;
                end
            end
            stFillWait: begin
                // Bank is still busy in the first wait cycle
                if (!bankBusy) begin
                    fill      = 1'b1;
                    nextState = (fillCnt == 2'd3) ? stAllocate : stFillIssue;
                end
            end
            stAllocate: nextState = stCompare;  // Retry with the new line
            stWriteMem: begin
                if (!bankBusy) begin
                    wrStrobe  = 1'b1;
                    nextState = stDone;
                end
            end
            stDone:  nextState = stIdle;
            default: nextState = stIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= stIdle;
            fillCnt <= '0;
            wasMiss <= 1'b0;
            hitSeen <= 1'b0;
        end else begin
            state <= nextState;
            if (state == stIdle) begin
                wasMiss <= 1'b0;
                hitSeen <= 1'b0;
            end
            // Only a read that hits on its first compare counts as a hit
            if ((state == stCompare) && Rd && !Wr) begin
                hitSeen <= hit && !wasMiss;
                if (!hit) begin
                    wasMiss <= 1'b1;
                end
            end
            if (fill) begin
                fillCnt <= fillCnt + 1'b1;  // Wraps to 0 after word 3
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(Done && Stall))
        else $error("cacheController: Done with Stall high");

endmodule

`default_nettype wire

//--- hw/memSysPkg.sv
// ----------------------------------------
// Memory system package
// Address split widths, bank count and
// the cache controller state encoding
// ----------------------------------------
`default_nettype none

package memSysPkg;

    // Word and byte address widths
    localparam int dataWidth = 16;
    localparam int addrWidth = 16;

    // Address split: tag 15..11, index 10..3, offset 2..0
    localparam int tagWidth    = 5;
    localparam int indexWidth  = 8;
    localparam int offsetWidth = 3;

    localparam int bankCount = 4;  // Also words per cache line

    // Controller states
    typedef enum logic [2:0] {
        stIdle,
        stCompare,
        stFillIssue,   // Waiting to strobe the next fill bank
        stFillWait,    // Waiting for that bank to return data
        stAllocate,
        stWriteMem,
        stDone
    } ctrlState_t;

endpackage

`default_nettype wire

//--- hw/memSystem.sv
// ----------------------------------------
// Memory system top level
// Write-through direct-mapped cache in
// front of a four-bank memory
// ----------------------------------------
`default_nettype none

module memSystem #(
    parameter int bankLatency = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [memSysPkg::addrWidth-1:0] Addr,
    input  logic [memSysPkg::dataWidth-1:0] DataIn,
    input  logic                           Rd,
    input  logic                           Wr,
    output logic [memSysPkg::dataWidth-1:0] DataOut,
    output logic                           Done,
    output logic                           Stall,
    output logic                           CacheHit,
    output logic                           err
);

    import memSysPkg::*;

    logic                  compare;
    logic                  writeWord;
    logic                  fill;
    logic                  hit;
    logic                  rdStrobe;
    logic                  wrStrobe;
    logic [1:0]            wordSel;
    logic [addrWidth-1:0]  memAddr;
    logic [bankCount-1:0]  busy;
    logic [dataWidth-1:0]  readData;
    logic [dataWidth-1:0]  arrayData;
    logic [tagWidth-1:0]   tagIn;
    logic [indexWidth-1:0] index;

    assign tagIn = Addr[addrWidth-1 -: tagWidth];
    assign index = Addr[offsetWidth +: indexWidth];

    assign arrayData = fill ? readData : DataIn;  // Memory data on fills

    cacheController ctrl (
        .clk       (clk),
        .rst       (rst),
        .Addr      (Addr),
        .Rd        (Rd),
        .Wr        (Wr),
        .hit       (hit),
        .busy      (busy),
        .Done      (Done),
        .Stall     (Stall),
        .CacheHit  (CacheHit),
        .err       (err),
        .compare   (compare),
        .writeWord (writeWord),
        .fill      (fill),
        .wordSel   (wordSel),
        .rdStrobe  (rdStrobe),
        .wrStrobe  (wrStrobe),
        .memAddr   (memAddr)
    );

    cacheArray cache (
        .clk       (clk),
        .rst       (rst),
        .compare   (compare),
        .writeWord (writeWord),
        .fill      (fill),
        .tagIn     (tagIn),
        .index     (index),
        .wordSel   (wordSel),
        .wrData    (arrayData),
        .hit       (hit),
        .dataOut   (DataOut)
    );

    bankedMemory #(
        .bankLatency (bankLatency)
    ) mem (
        .clk      (clk),
        .rst      (rst),
        .rdStrobe (rdStrobe),
        .wrStrobe (wrStrobe),
        .memAddr  (memAddr),
        .wrData   (DataIn),
        .readData (readData),
        .busy     (busy)
    );

endmodule

`default_nettype wire

//--- project.f
hw/memSysPkg.sv
hw/cacheArray.sv
hw/bankedMemory.sv
hw/cacheController.sv
hw/memSystem.sv
bench/memSystemTb.sv
